// File: design/iir_config.svh
//////////////////////////////////////////////////
// Global width and size macros for the IIR chain
// Sample width, coefficient fraction bits and
// number of chained biquad sections
//////////////////////////////////////////////////

`ifndef IIR_CONFIG_SVH
`define IIR_CONFIG_SVH

// Width of samples and coefficients
`define IIR_N_BITS 16

// Fraction bits of the coefficients, 1.0 is 2**14
`define IIR_Q_BITS 14

// Number of second-order sections in the chain
`define IIR_N_SECTIONS 2

`endif

// File: design/iir_pkg.sv
//////////////////////////////////////////////////
// Shared types of the IIR filter chain
// Sample, coefficient and product vectors, the
// coefficient set and write structs, stage enum
//////////////////////////////////////////////////

`include "iir_config.svh"

package iir_pkg;

  // Section number width, at least one bit
  localparam int section_idx_bits =
    (`IIR_N_SECTIONS > 1) ? $clog2(`IIR_N_SECTIONS) : 1;

  typedef logic signed [`IIR_N_BITS-1:0]   sample_t;
  typedef logic signed [`IIR_N_BITS-1:0]   coef_t;
  // Full multiplier result before the Q slice
  typedef logic signed [2*`IIR_N_BITS-1:0] product_t;
  typedef logic [section_idx_bits-1:0]     section_idx_t;
  // 0 b0, 1 b1, 2 b2, 3 a1, 4 a2, rest unused
  typedef logic [2:0]                      coef_idx_t;

  // All five coefficients of one section
  typedef struct packed {
    coef_t b0;
    coef_t b1;
    coef_t b2;
    coef_t a1;
    coef_t a2;
  } coef_set_t;

  // One coefficient write from software
  typedef struct packed {
    section_idx_t section;
    coef_idx_t    index;
    coef_t        data;
  } coef_wr_t;

  // Stages of the time-shared multiply-accumulate
  typedef enum logic [2:0] {
    stage_idle,
    stage_b1,
    stage_b2,
    stage_a1,
    stage_a2,
    stage_out
  } biquad_stage_t;

endpackage

// File: design/iir_coef_regs.sv
//////////////////////////////////////////////////
// Coefficient register file of the IIR chain
// One coefficient set per section, written by a
// strobe with section, index and data
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_config.svh"

module iir_coef_regs (
  input  logic                clk,
  input  logic                rst_n,
  // Write port from software
  input  logic                cfg_we,
  input  iir_pkg::coef_wr_t   cfg_wr,
  // Coefficient set of every section
  output iir_pkg::coef_set_t  coefs [`IIR_N_SECTIONS]
);

  import iir_pkg::*;

  // One bit per section addressed by the write
  logic [`IIR_N_SECTIONS-1:0] section_hit;
  // One-hot field select, b0 in bit 0 up to a2 in bit 4
  logic [4:0]                 field_we;

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  // Section match, numbers past the last section hit nothing
  always_comb begin
    section_hit = '0;
    for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
      if (cfg_we && (cfg_wr.section == section_idx_t'(s))) begin
        section_hit[s] = 1'b1;
      end
    end
  end

  // Field select from the coefficient index
  always_comb begin
    field_we = '0;
    case (cfg_wr.index)
      3'd0: field_we[0] = 1'b1;
      3'd1: field_we[1] = 1'b1;
      3'd2: field_we[2] = 1'b1;
      3'd3: field_we[3] = 1'b1;
      3'd4: field_we[4] = 1'b1;
      // Indices 5 to 7 select no field
      default: field_we = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Register storage
  //////////////////////////////////////////////////

  // Visible on coefs one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
        coefs[s] <= '0;
      end
    end else begin
      for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
        if (section_hit[s]) begin
          // Zeros
          if (field_we[0]) begin
            coefs[s].b0 <= cfg_wr.data;
          end
          if (field_we[1]) begin
            coefs[s].b1 <= cfg_wr.data;
          end
          if (field_we[2]) begin
            coefs[s].b2 <= cfg_wr.data;
          end
          // Poles
          if (field_we[3]) begin
            coefs[s].a1 <= cfg_wr.data;
          end
          if (field_we[4]) begin
            coefs[s].a2 <= cfg_wr.data;
          end
        end
      end
    end
  end

endmodule

// File: design/iir_biquad_core.sv
//////////////////////////////////////////////////
// Direct-Form I biquad section
// One shared multiplier stepped over six stages
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_config.svh"

module iir_biquad_core (
  input  logic               clk,
  input  logic               rst_n,
  // Sample input with valid/ready
  input  iir_pkg::sample_t   x,
  input  logic               x_valid,
  output logic               x_ready,
  // Result with a one-cycle valid pulse
  output iir_pkg::sample_t   y,
  output logic               y_valid,
  // Coefficients of this section
  input  iir_pkg::coef_set_t coefs
);

  import iir_pkg::*;

  // Bits of the product kept after Q alignment
  localparam int slice_lo = `IIR_Q_BITS;
  localparam int slice_hi = `IIR_N_BITS + `IIR_Q_BITS - 1;

  biquad_stage_t stage;
  logic          accept;

  // Sample taken at accept, x[n-1], x[n-2] and y[n-2]
  // y itself serves as y[n-1]
  sample_t       x_lat;
  sample_t       x_d1;
  sample_t       x_d2;
  sample_t       y_d2;

  // Shared multiplier operands and registered product
  coef_t         mul_coef;
  sample_t       mul_data;
  product_t      product;
  sample_t       product_slice;
  // Wrapping N-bit running sum
  sample_t       acc;

  assign accept        = (stage == stage_idle) && x_valid && x_ready;
  assign product_slice = product[slice_hi:slice_lo];

  //////////////////////////////////////////////////
  // Multiplier operand select
  //////////////////////////////////////////////////

  always_comb begin
    // Idle feeds b0*x[n] so the product is ready at accept
    mul_coef = coefs.b0;
    mul_data = x;
    case (stage)
      stage_b1: begin
        mul_coef = coefs.b1;
        mul_data = x_d1;
      end
      stage_b2: begin
        mul_coef = coefs.b2;
        mul_data = x_d2;
      end
      stage_a1: begin
        mul_coef = coefs.a1;
        mul_data = y;
      end
      stage_a2: begin
        mul_coef = coefs.a2;
        mul_data = y_d2;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Stage control, delay lines and output
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage   <= stage_idle;
      x_ready <= 1'b0;
      y_valid <= 1'b0;
      y       <= '0;
      x_d1    <= '0;
      x_d2    <= '0;
      y_d2    <= '0;
    end else begin
      // Valid is a single-cycle pulse
      y_valid <= 1'b0;
      case (stage)
        stage_idle: begin
          // Ready rises one idle cycle after entry, drops on accept
          x_ready <= !accept;
          if (accept) begin
            stage <= stage_b1;
          end
        end
        stage_b1: stage <= stage_b2;
        stage_b2: stage <= stage_a1;
        stage_a1: stage <= stage_a2;
        stage_a2: stage <= stage_out;
        stage_out: begin
          stage   <= stage_idle;
          y_valid <= 1'b1;
          // Last term is -a2*y[n-2]
          y       <= acc - product_slice;
          // Shift both delay lines by one sample
          x_d1    <= x_lat;
          x_d2    <= x_d1;
          y_d2    <= y;
        end
        default: stage <= stage_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Multiply-accumulate datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (stage)
      stage_idle: begin
        if (accept) begin
          // Source may change x after this edge
          x_lat   <= x;
          product <= mul_coef * mul_data;
        end
      end
      stage_b1: begin
        // Start the sum with b0*x[n]
        acc     <= product_slice;
        product <= mul_coef * mul_data;
      end
      stage_b2, stage_a1: begin
        // Add b1*x[n-1], then b2*x[n-2]
        acc     <= acc + product_slice;
        product <= mul_coef * mul_data;
      end
      stage_a2: begin
        // Subtract a1*y[n-1]
        acc     <= acc - product_slice;
        product <= mul_coef * mul_data;
      end
      default: ;
    endcase
  end

endmodule

// File: design/iir_filter_top.sv
//////////////////////////////////////////////////
// IIR filter top level
// Coefficient registers and a chain of biquads
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_config.svh"

module iir_filter_top (
  input  logic              clk,
  input  logic              rst_n,
  // Coefficient write strobe
  input  logic              cfg_we,
  input  iir_pkg::coef_wr_t cfg_wr,
  // Sample input with valid/ready
  input  iir_pkg::sample_t  x,
  input  logic              x_valid,
  output logic              x_ready,
  // Filtered output, valid pulse only
  output iir_pkg::sample_t  y,
  output logic              y_valid
);

  import iir_pkg::*;

  // Coefficient set per section
  coef_set_t sec_coefs   [`IIR_N_SECTIONS];
  // Chain links, element k feeds section k
  sample_t   chain_x     [`IIR_N_SECTIONS+1];
  logic      chain_valid [`IIR_N_SECTIONS+1];

  // Chain ends
  assign chain_x[0]     = x;
  assign chain_valid[0] = x_valid;
  assign y              = chain_x[`IIR_N_SECTIONS];
  assign y_valid        = chain_valid[`IIR_N_SECTIONS];

  iir_coef_regs u_coef_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .cfg_we (cfg_we),
    .cfg_wr (cfg_wr),
    .coefs  (sec_coefs)
  );

  //////////////////////////////////////////////////
  // Section chain
  //////////////////////////////////////////////////

  for (genvar k = 0; k < `IIR_N_SECTIONS; k++) begin : g_section
    if (k == 0) begin : g_first
      // Only the first section drives back-pressure to the source
      iir_biquad_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .x       (chain_x[k]),
        .x_valid (chain_valid[k]),
        .x_ready (x_ready),
        .y       (chain_x[k+1]),
        .y_valid (chain_valid[k+1]),
        .coefs   (sec_coefs[k])
      );
    end else begin : g_inner
      // Always idle when the upstream pulse arrives
      iir_biquad_core u_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .x       (chain_x[k]),
        .x_valid (chain_valid[k]),
        .x_ready (),
        .y       (chain_x[k+1]),
        .y_valid (chain_valid[k+1]),
        .coefs   (sec_coefs[k])
      );
    end
  end

endmodule

// File: verif/iir_filter_assertions.sv
//////////////////////////////////////////////////
// Bound assertions for the IIR filter top level
// Reset values, valid pulse width, ready drop
//////////////////////////////////////////////////

`timescale 1ns/1ps

module iir_filter_assertions (
  input logic clk,
  input logic rst_n,
  input logic x_valid,
  input logic x_ready,
  input logic y_valid
);

  // Number of assertion failures, read back by the testbench
  int failures = 0;

  // Both handshake outputs are cleared while reset is low
  reset_outputs_low: assert property (@(posedge clk) !rst_n |-> (!x_ready && !y_valid))
    else begin
      failures++;
      $error("x_ready or y_valid high during reset");
    end

  // Output valid is a single-cycle pulse
  single_cycle_valid: assert property (@(posedge clk) disable iff (!rst_n)
    y_valid |=> !y_valid)
    else begin
      failures++;
      $error("y_valid high for two cycles in a row");
    end

  // First section is busy right after an accept
  ready_drops_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (x_valid && x_ready) |=> !x_ready)
    else begin
      failures++;
      $error("x_ready still high in the cycle after an accept");
    end

endmodule

bind iir_filter_top iir_filter_assertions u_assertions (
  .clk     (clk),
  .rst_n   (rst_n),
  .x_valid (x_valid),
  .x_ready (x_ready),
  .y_valid (y_valid)
);

// File: verif/iir_filter_checker.sv
//////////////////////////////////////////////////
// Checker for the IIR filter chain
// Coefficient and delay-line model, output and
// latency compare, per-test and total counts
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_config.svh"

module iir_filter_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cfg_we,
  input  iir_pkg::coef_wr_t cfg_wr,
  input  iir_pkg::sample_t  x,
  input  logic              x_valid,
  input  logic              x_ready,
  input  iir_pkg::sample_t  y,
  input  logic              y_valid,
  input  int                test_id,
  output int                error_count,
  output int                pending
);

  import iir_pkg::*;

  // Accept to output, six stages per section
  localparam int latency   = 6 * `IIR_N_SECTIONS;
  localparam int last_test = 6;

  // Model of the register file, b0 b1 b2 a1 a2 per section
  coef_t   m_coef [`IIR_N_SECTIONS][5];
  // Model delay lines of every section
  sample_t m_x1   [`IIR_N_SECTIONS];
  sample_t m_x2   [`IIR_N_SECTIONS];
  sample_t m_y1   [`IIR_N_SECTIONS];
  sample_t m_y2   [`IIR_N_SECTIONS];

  // Samples in flight, oldest first
  sample_t exp_y      [$];
  int      accept_cyc [$];

  int cycle        = 0;
  int cur_test     = 0;
  int test_checks  = 0;
  int test_errors  = 0;
  int total_checks = 0;

  initial begin
    error_count = 0;
    pending     = 0;
  end

  function automatic string test_label(input int id);
    case (id)
      1: return "reset";
      2: return "pass_through";
      3: return "random";
      4: return "latency";
      5: return "section";
      default: return "none";
    endcase
  endfunction

  // Q-aligned slice of the full signed product
  function automatic sample_t q_product(input coef_t c, input sample_t d);
    logic signed [2*`IIR_N_BITS-1:0] cw;
    logic signed [2*`IIR_N_BITS-1:0] dw;
    logic signed [2*`IIR_N_BITS-1:0] full;
    cw   = {{`IIR_N_BITS{c[`IIR_N_BITS-1]}}, c};
    dw   = {{`IIR_N_BITS{d[`IIR_N_BITS-1]}}, d};
    full = cw * dw;
    return full[`IIR_Q_BITS +: `IIR_N_BITS];
  endfunction

  // One Direct-Form I step, N-bit wrap, updates the delay lines
  function automatic sample_t section_step(input int s, input sample_t xin);
    sample_t acc;
    acc = q_product(m_coef[s][0], xin) + q_product(m_coef[s][1], m_x1[s])
        + q_product(m_coef[s][2], m_x2[s]) - q_product(m_coef[s][3], m_y1[s])
        - q_product(m_coef[s][4], m_y2[s]);
    m_x2[s] = m_x1[s];
    m_x1[s] = xin;
    m_y2[s] = m_y1[s];
    m_y1[s] = acc;
    return acc;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    test_checks++;
    total_checks++;
    if (expected != actual) begin
      $display("[FAIL] %s %s: expected %0d actual %0d",
               test_label(cur_test), what, expected, actual);
      test_errors++;
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor, sampled at the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    sample_t v;
    int      t;
    cycle++;
    // Close the previous test when the id moves on
    if (test_id != cur_test) begin
      if (cur_test != 0) begin
        $display("%s done: %0d checks, %0d errors",
                 test_label(cur_test), test_checks, test_errors);
      end
      if (test_id == last_test) begin
        $display("Total: %0d checks, %0d errors", total_checks, error_count);
      end
      cur_test    = test_id;
      test_checks = 0;
      test_errors = 0;
    end
    if (!rst_n) begin
      check_value("x_ready in reset", 0, int'(x_ready));
      check_value("y_valid in reset", 0, int'(y_valid));
      for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
        for (int i = 0; i < 5; i++) begin
          m_coef[s][i] = '0;
        end
        m_x1[s] = '0;
        m_x2[s] = '0;
        m_y1[s] = '0;
        m_y2[s] = '0;
      end
      exp_y.delete();
      accept_cyc.delete();
    end else begin
      if (y_valid) begin
        if (exp_y.size() == 0) begin
          $display("%s: y_valid pulsed with no sample in flight", test_label(cur_test));
          test_errors++;
          error_count++;
        end else begin
          v = exp_y.pop_front();
          t = accept_cyc.pop_front();
          check_value("y", int'(v), int'(y));
          check_value("latency", latency, cycle - t);
        end
      end
      // Whole chain result is known at accept
      if (x_valid && x_ready) begin
        v = x;
        for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
          v = section_step(s, v);
        end
        exp_y.push_back(v);
        accept_cyc.push_back(cycle);
      end
      // Write takes effect after this edge, indices 5 to 7 dropped
      if (cfg_we && (int'(cfg_wr.index) < 5) && (int'(cfg_wr.section) < `IIR_N_SECTIONS)) begin
        m_coef[int'(cfg_wr.section)][int'(cfg_wr.index)] = cfg_wr.data;
      end
    end
    pending = exp_y.size();
  end

endmodule

// File: verif/iir_filter_tb.sv
//////////////////////////////////////////////////
// Testbench top for the IIR filter chain
// Clock, reset, coefficient writes and seeded
// random samples over five tests
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "iir_config.svh"

module iir_filter_tb;

  import iir_pkg::*;

  // Cycles any single wait may take
  localparam int wait_limit = 400;
  localparam int test_end   = 6;

  logic     clk = 1'b1;
  logic     rst_n;
  logic     cfg_we;
  coef_wr_t cfg_wr;
  sample_t  x;
  logic     x_valid;
  logic     x_ready;
  sample_t  y;
  logic     y_valid;
  int       test_id;
  int       error_count;
  int       pending;
  // Set once any wait has run out of cycles
  bit       timed_out = 1'b0;

  // 8 ns period, first falling edge at 4 ns
  always #4 clk = ~clk;

  iir_filter_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_we  (cfg_we),
    .cfg_wr  (cfg_wr),
    .x       (x),
    .x_valid (x_valid),
    .x_ready (x_ready),
    .y       (y),
    .y_valid (y_valid)
  );

  iir_filter_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_wr      (cfg_wr),
    .x           (x),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .y           (y),
    .y_valid     (y_valid),
    .test_id     (test_id),
    .error_count (error_count),
    .pending     (pending)
  );

  // Remaining stimulus is skipped once this is set
  task automatic report_timeout(input string reason);
    $display("Timeout: %s", reason);
    timed_out = 1'b1;
  endtask

  // Random Q coefficient with magnitude below 0.5
  function automatic coef_t rand_coef();
    int v;
    v = int'($urandom_range(16382)) - 8191;
    return coef_t'(v);
  endfunction

  task automatic write_coef(input int section, input int index, input int data);
    if (!timed_out) begin
      cfg_we         = 1'b1;
      cfg_wr.section = section_idx_t'(section);
      cfg_wr.index   = coef_idx_t'(index);
      cfg_wr.data    = coef_t'(data);
      @(negedge clk);
      cfg_we = 1'b0;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!timed_out && (x_ready !== 1'b1)) begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        report_timeout("x_ready never went high");
      end
    end
  endtask

  // Chain is idle once every sample has come out
  task automatic wait_drained();
    int n;
    n = 0;
    while (!timed_out && ((pending != 0) || (x_ready !== 1'b1))) begin
      @(negedge clk);
      n++;
      if (n > wait_limit) begin
        report_timeout("outputs still missing after the last input");
      end
    end
  endtask

  // Hold the sample until accepted, then scramble x
  task automatic send_sample(input sample_t value, input int gap);
    if (!timed_out) begin
      x       = value;
      x_valid = 1'b1;
      wait_ready();
      @(negedge clk);
      x_valid = 1'b0;
      x       = sample_t'($urandom);
      repeat (gap) @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h2607));
    rst_n   = 1'b1;
    cfg_we  = 1'b0;
    cfg_wr  = '0;
    x       = '0;
    x_valid = 1'b0;
    test_id = 0;

    // Reset held for 10 cycles
    test_id = 1;
    @(negedge clk);
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    wait_ready();

    // Unit gain in every section
    test_id = 2;
    for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
      write_coef(s, 0, 16384);
      for (int i = 1; i < 5; i++) begin
        write_coef(s, i, 0);
      end
    end
    repeat (40) send_sample(sample_t'($urandom), int'($urandom_range(2)));
    wait_drained();

    // Random coefficients and samples with idle gaps
    test_id = 3;
    for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
      for (int i = 0; i < 5; i++) begin
        write_coef(s, i, int'(rand_coef()));
      end
    end
    repeat (300) send_sample(sample_t'($urandom), int'($urandom_range(3)));
    wait_drained();

    // Back to back, no gaps
    test_id = 4;
    repeat (60) send_sample(sample_t'($urandom), 0);
    wait_drained();

    // Section 0 rings with a1 = -0.5, section 1 is unit gain
    test_id = 5;
    write_coef(1, 0, 16384);
    for (int i = 1; i < 5; i++) begin
      write_coef(1, i, 0);
    end
    write_coef(0, 0, 16384);
    write_coef(0, 1, 0);
    write_coef(0, 2, 0);
    write_coef(0, 3, -8192);
    write_coef(0, 4, 0);
    repeat (16) send_sample('0, 0);
    send_sample(sample_t'(12000), 0);
    repeat (24) send_sample('0, 0);
    wait_drained();
    // Unused indices must not touch any coefficient
    for (int s = 0; s < `IIR_N_SECTIONS; s++) begin
      for (int i = 5; i < 8; i++) begin
        write_coef(s, i, int'(rand_coef()));
      end
    end
    send_sample(sample_t'(12000), 0);
    repeat (24) send_sample('0, int'($urandom_range(1)));
    wait_drained();

    test_id = test_end;
    repeat (2) @(negedge clk);
    if (!timed_out && (error_count == 0) && (UUT.u_assertions.failures == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/iir_pkg.sv
design/iir_coef_regs.sv
design/iir_biquad_core.sv
design/iir_filter_top.sv
verif/iir_filter_assertions.sv
verif/iir_filter_checker.sv
verif/iir_filter_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the IIR filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module iir_filter_tb -f all.f -Mdir obj_dir -o iir_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/iir_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  exit 0
fi
echo "No pass line found in $LOG"
exit 1
